/* verilog/ooo_pkg.sv */
package ooo_pkg;

    // Usable ROB entries; tags run 1..ROB_DEPTH and tag 0 means no producer
    localparam int ROB_DEPTH = 7;
    localparam int NUM_REGS  = 32;

    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  rob_tag_t;
    typedef logic [3:0]  op_t;

    localparam op_t OP_ADD  = 4'h0;
    localparam op_t OP_SUB  = 4'h1;
    localparam op_t OP_AND  = 4'h2;
    localparam op_t OP_OR   = 4'h3;
    localparam op_t OP_XOR  = 4'h4;
    localparam op_t OP_SLT  = 4'h5;
    localparam op_t OP_ADDI = 4'h6;
    localparam op_t OP_LUI  = 4'h7;
    localparam op_t OP_BEQ  = 4'h8;
    localparam op_t OP_BNE  = 4'h9;

    // Branches never write a register and report a taken flag at commit
    function automatic logic is_branch(input op_t op);
        return (op == OP_BEQ) || (op == OP_BNE);
    endfunction

    // Operand 2 comes from the immediate for these
    function automatic logic uses_imm(input op_t op);
        return (op == OP_ADDI) || (op == OP_LUI);
    endfunction

endpackage

/* verilog/issue_if.sv */
`timescale 1ns/1ps

interface issue_if;
    logic              valid;
    ooo_pkg::op_t      op;
    ooo_pkg::reg_idx_t rd;
    ooo_pkg::rob_tag_t tag;
    ooo_pkg::data_t    val1;
    ooo_pkg::rob_tag_t tag1;
    ooo_pkg::data_t    val2;
    ooo_pkg::rob_tag_t tag2;
    ooo_pkg::data_t    imm;

    // A nonzero tag1 or tag2 marks that operand as still pending
    modport source (
        output valid, op, rd, tag, val1, tag1, val2, tag2, imm
    );

    modport sink (
        input valid, op, rd, tag, val1, tag1, val2, tag2, imm
    );
endinterface

/* verilog/result_ifs.sv */
`timescale 1ns/1ps

// Result broadcast from the execute unit, one cycle per result
interface cdb_if;
    logic              valid;
    ooo_pkg::rob_tag_t tag;
    ooo_pkg::data_t    value;
    logic              taken;

    modport source (output valid, tag, value, taken);

    modport monitor (input valid, tag, value, taken);
endinterface

// In-order retirement from the ROB to the register file
interface commit_if;
    logic              valid;
    ooo_pkg::reg_idx_t rd;
    ooo_pkg::rob_tag_t tag;
    ooo_pkg::data_t    value;

    modport source (output valid, rd, tag, value);

    modport sink (input valid, rd, tag, value);
endinterface

/* verilog/rename_table.sv */
`timescale 1ns/1ps

module rename_table (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_valid,
    input  ooo_pkg::op_t      issue_op,
    input  ooo_pkg::reg_idx_t issue_rd,
    input  ooo_pkg::reg_idx_t issue_rs1,
    input  ooo_pkg::reg_idx_t issue_rs2,
    input  ooo_pkg::data_t    issue_imm,
    input  ooo_pkg::rob_tag_t alloc_tag,
    issue_if.source           iss,
    commit_if.sink            cmt,
    cdb_if.monitor            cdb,
    output ooo_pkg::rob_tag_t query1_tag,
    output ooo_pkg::rob_tag_t query2_tag,
    input  logic              query1_ready,
    input  logic              query2_ready,
    input  ooo_pkg::data_t    query1_value,
    input  ooo_pkg::data_t    query2_value
);

    ooo_pkg::data_t    regs [ooo_pkg::NUM_REGS];
    ooo_pkg::rob_tag_t prod [ooo_pkg::NUM_REGS];
    ooo_pkg::rob_tag_t tag1;
    ooo_pkg::rob_tag_t tag2;
    ooo_pkg::data_t    val1;
    ooo_pkg::data_t    val2;
    logic              renames;

    // Operands come from the register file, then the ROB, then the CDB, else stay pending
    function automatic void resolve(input ooo_pkg::reg_idx_t rs, input ooo_pkg::rob_tag_t ptag,
                                    input logic rob_ready, input ooo_pkg::data_t rob_value,
                                    output ooo_pkg::rob_tag_t tag, output ooo_pkg::data_t val);
        tag = '0;
        if (ptag == '0) begin
            if (cmt.valid && cmt.rd == rs && rs != '0)
                val = cmt.value;
            else
                val = regs[rs];
        end else if (rob_ready) begin
            val = rob_value;
        end else if (cdb.valid && cdb.tag == ptag) begin
            val = cdb.value;
        end else begin
            val = '0;
            tag = ptag;
        end
    endfunction

    assign query1_tag = prod[issue_rs1];
    assign query2_tag = prod[issue_rs2];
    assign renames    = issue_valid && issue_rd != '0 && !ooo_pkg::is_branch(issue_op);

    always_comb begin
        resolve(issue_rs1, query1_tag, query1_ready, query1_value, tag1, val1);
        resolve(issue_rs2, query2_tag, query2_ready, query2_value, tag2, val2);
        iss.valid = issue_valid;
        iss.op    = issue_op;
        iss.rd    = issue_rd;
        iss.tag   = alloc_tag;
        iss.imm   = issue_imm;
        iss.val1  = val1;
        iss.tag1  = tag1;
        iss.val2  = ooo_pkg::uses_imm(issue_op) ? issue_imm : val2;
        iss.tag2  = ooo_pkg::uses_imm(issue_op) ? '0 : tag2;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int r = 0; r < ooo_pkg::NUM_REGS; r++) begin
                regs[r] <= '0;
                prod[r] <= '0;
            end
        end else begin
            if (cmt.valid && cmt.rd != '0) begin
                regs[cmt.rd] <= cmt.value;
                if (prod[cmt.rd] == cmt.tag)
                    prod[cmt.rd] <= '0;
            end
            // A rename in the same cycle overrides the clear above
            if (renames)
                prod[issue_rd] <= alloc_tag;
        end
    end

    // The latest writer of a register commits last, so a committing register still has a producer
    a_commit_has_producer: assert property (@(posedge clk) disable iff (!rst)
        cmt.valid && cmt.rd != '0 |-> prod[cmt.rd] != '0);

endmodule

/* verilog/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer (
    input  logic              clk,
    input  logic              rst,
    issue_if.sink             iss,
    cdb_if.monitor            cdb,
    commit_if.source          cmt,
    output ooo_pkg::rob_tag_t alloc_tag,
    input  ooo_pkg::rob_tag_t query1_tag,
    input  ooo_pkg::rob_tag_t query2_tag,
    output logic              query1_ready,
    output logic              query2_ready,
    output ooo_pkg::data_t    query1_value,
    output ooo_pkg::data_t    query2_value,
    output logic              credit,
    output logic              commit_branch,
    output logic              commit_taken
);

    // Entry 0 is never allocated so that tag 0 stays free for "no producer"
    logic [ooo_pkg::ROB_DEPTH:0] busy;
    logic [ooo_pkg::ROB_DEPTH:0] ready;
    ooo_pkg::op_t                ent_op    [0:ooo_pkg::ROB_DEPTH];
    ooo_pkg::reg_idx_t           ent_rd    [0:ooo_pkg::ROB_DEPTH];
    ooo_pkg::data_t              ent_value [0:ooo_pkg::ROB_DEPTH];
    logic                        ent_taken [0:ooo_pkg::ROB_DEPTH];
    ooo_pkg::rob_tag_t           head;
    ooo_pkg::rob_tag_t           tail;
    logic                        head_done;

    function automatic ooo_pkg::rob_tag_t advance(input ooo_pkg::rob_tag_t t);
        return (t == ooo_pkg::rob_tag_t'(ooo_pkg::ROB_DEPTH)) ? ooo_pkg::rob_tag_t'(1) : t + 1'b1;
    endfunction

    assign alloc_tag = tail;
    assign head_done = busy[head] && ready[head];

    // Ready stays set after commit so a rename still pointing here reads the value
    assign query1_ready = ready[query1_tag];
    assign query2_ready = ready[query2_tag];
    assign query1_value = ent_value[query1_tag];
    assign query2_value = ent_value[query2_tag];

    always_ff @(posedge clk) begin
        if (!rst) begin
            head          <= ooo_pkg::rob_tag_t'(1);
            tail          <= ooo_pkg::rob_tag_t'(1);
            busy          <= '0;
            ready         <= '0;
            cmt.valid     <= 1'b0;
            credit        <= 1'b0;
            commit_branch <= 1'b0;
            commit_taken  <= 1'b0;
        end else begin
            cmt.valid     <= head_done;
            credit        <= head_done;
            commit_branch <= head_done && ooo_pkg::is_branch(ent_op[head]);
            commit_taken  <= head_done && ent_taken[head];
            if (head_done) begin
                busy[head] <= 1'b0;
                head       <= advance(head);
                cmt.rd     <= ent_rd[head];
                cmt.tag    <= head;
                cmt.value  <= ent_value[head];
            end
            if (cdb.valid) begin
                ready[cdb.tag]     <= 1'b1;
                ent_value[cdb.tag] <= cdb.value;
                ent_taken[cdb.tag] <= cdb.taken;
            end
            // LUI needs no execution, its value is the immediate
            if (iss.valid) begin
                busy[iss.tag]      <= 1'b1;
                ready[iss.tag]     <= iss.op == ooo_pkg::OP_LUI;
                ent_op[iss.tag]    <= iss.op;
                ent_rd[iss.tag]    <= ooo_pkg::is_branch(iss.op) ? '0 : iss.rd;
                ent_value[iss.tag] <= iss.imm;
                ent_taken[iss.tag] <= 1'b0;
                tail               <= advance(tail);
            end
        end
    end

    a_issue_free: assert property (@(posedge clk) disable iff (!rst) iss.valid |-> !busy[iss.tag]);

    a_cdb_busy: assert property (@(posedge clk) disable iff (!rst) cdb.valid |-> busy[cdb.tag]);

endmodule

/* verilog/reservation_station.sv */
`timescale 1ns/1ps

module reservation_station (
    input  logic              clk,
    input  logic              rst,
    issue_if.sink             iss,
    cdb_if.monitor            cdb,
    output logic              sel_valid,
    output ooo_pkg::op_t      sel_op,
    output ooo_pkg::rob_tag_t sel_tag,
    output ooo_pkg::data_t    sel_a,
    output ooo_pkg::data_t    sel_b
);

    // One slot per ROB tag, so the station can never fill up
    logic [ooo_pkg::ROB_DEPTH:0] slot_used;
    logic [ooo_pkg::ROB_DEPTH:0] slot_ready;
    ooo_pkg::op_t                slot_op [0:ooo_pkg::ROB_DEPTH];
    ooo_pkg::data_t              slot_v1 [0:ooo_pkg::ROB_DEPTH];
    ooo_pkg::data_t              slot_v2 [0:ooo_pkg::ROB_DEPTH];
    ooo_pkg::rob_tag_t           slot_t1 [0:ooo_pkg::ROB_DEPTH];
    ooo_pkg::rob_tag_t           slot_t2 [0:ooo_pkg::ROB_DEPTH];

    always_comb begin
        slot_ready = '0;
        sel_valid  = 1'b0;
        sel_tag    = '0;
        for (int k = 1; k <= ooo_pkg::ROB_DEPTH; k++)
            slot_ready[k] = slot_used[k] && slot_t1[k] == '0 && slot_t2[k] == '0;
        // Walk down so the lowest ready tag is the one left selected
        for (int k = ooo_pkg::ROB_DEPTH; k >= 1; k--) begin
            if (slot_ready[k]) begin
                sel_valid = 1'b1;
                sel_tag   = ooo_pkg::rob_tag_t'(k);
            end
        end
        sel_op = slot_op[sel_tag];
        sel_a  = slot_v1[sel_tag];
        sel_b  = slot_v2[sel_tag];
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            slot_used <= '0;
        end else begin
            if (sel_valid)
                slot_used[sel_tag] <= 1'b0;
            if (cdb.valid) begin
                for (int k = 1; k <= ooo_pkg::ROB_DEPTH; k++) begin
                    if (slot_used[k] && slot_t1[k] == cdb.tag) begin
                        slot_t1[k] <= '0;
                        slot_v1[k] <= cdb.value;
                    end
                    if (slot_used[k] && slot_t2[k] == cdb.tag) begin
                        slot_t2[k] <= '0;
                        slot_v2[k] <= cdb.value;
                    end
                end
            end
            if (iss.valid && iss.op != ooo_pkg::OP_LUI) begin
                slot_used[iss.tag] <= 1'b1;
                slot_op[iss.tag]   <= iss.op;
                slot_v1[iss.tag]   <= iss.val1;
                slot_t1[iss.tag]   <= iss.tag1;
                slot_v2[iss.tag]   <= iss.val2;
                slot_t2[iss.tag]   <= iss.tag2;
            end
        end
    end

    // A slot is freed at selection, well before its tag can be handed out again
    a_issue_slot_free: assert property (@(posedge clk) disable iff (!rst)
        iss.valid && iss.op != ooo_pkg::OP_LUI |-> !slot_used[iss.tag]);

endmodule

/* verilog/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              sel_valid,
    input  ooo_pkg::op_t      sel_op,
    input  ooo_pkg::rob_tag_t sel_tag,
    input  ooo_pkg::data_t    sel_a,
    input  ooo_pkg::data_t    sel_b,
    cdb_if.source             cdb
);

    ooo_pkg::data_t result;
    logic           taken;

    always_comb begin
        unique case (sel_op)
            ooo_pkg::OP_ADD,
            ooo_pkg::OP_ADDI: result = sel_a + sel_b;
            ooo_pkg::OP_SUB:  result = sel_a - sel_b;
            ooo_pkg::OP_AND:  result = sel_a & sel_b;
            ooo_pkg::OP_OR:   result = sel_a | sel_b;
            ooo_pkg::OP_XOR:  result = sel_a ^ sel_b;
            ooo_pkg::OP_SLT:  result = {31'b0, $signed(sel_a) < $signed(sel_b)};
            default:          result = '0;
        endcase
        // Branches carry value 0 and only report the compare outcome
        taken = (sel_op == ooo_pkg::OP_BEQ && sel_a == sel_b) ||
                (sel_op == ooo_pkg::OP_BNE && sel_a != sel_b);
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= sel_valid;
            cdb.tag   <= sel_tag;
            cdb.value <= result;
            cdb.taken <= taken;
        end
    end

endmodule

/* verilog/ooo_core.sv */
`timescale 1ns/1ps

module ooo_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_valid,
    input  ooo_pkg::op_t      issue_op,
    input  ooo_pkg::reg_idx_t issue_rd,
    input  ooo_pkg::reg_idx_t issue_rs1,
    input  ooo_pkg::reg_idx_t issue_rs2,
    input  ooo_pkg::data_t    issue_imm,
    output logic              credit,
    output logic              commit_valid,
    output ooo_pkg::reg_idx_t commit_rd,
    output ooo_pkg::data_t    commit_value,
    output logic              commit_branch,
    output logic              commit_taken
);

    issue_if  iss_bus ();
    cdb_if    cdb_bus ();
    commit_if cmt_bus ();

    ooo_pkg::rob_tag_t alloc_tag;
    ooo_pkg::rob_tag_t query1_tag;
    ooo_pkg::rob_tag_t query2_tag;
    logic              query1_ready;
    logic              query2_ready;
    ooo_pkg::data_t    query1_value;
    ooo_pkg::data_t    query2_value;
    logic              sel_valid;
    ooo_pkg::op_t      sel_op;
    ooo_pkg::rob_tag_t sel_tag;
    ooo_pkg::data_t    sel_a;
    ooo_pkg::data_t    sel_b;

    rename_table u_rename (
        .clk, .rst, .issue_valid, .issue_op, .issue_rd, .issue_rs1, .issue_rs2, .issue_imm,
        .alloc_tag, .iss(iss_bus), .cmt(cmt_bus), .cdb(cdb_bus),
        .query1_tag, .query2_tag, .query1_ready, .query2_ready, .query1_value, .query2_value
    );

    reorder_buffer u_rob (
        .clk, .rst, .iss(iss_bus), .cdb(cdb_bus), .cmt(cmt_bus), .alloc_tag,
        .query1_tag, .query2_tag, .query1_ready, .query2_ready, .query1_value, .query2_value,
        .credit, .commit_branch, .commit_taken
    );

    reservation_station u_rs (
        .clk, .rst, .iss(iss_bus), .cdb(cdb_bus),
        .sel_valid, .sel_op, .sel_tag, .sel_a, .sel_b
    );

    execute_unit u_exec (
        .clk, .rst, .sel_valid, .sel_op, .sel_tag, .sel_a, .sel_b, .cdb(cdb_bus)
    );

    assign commit_valid = cmt_bus.valid;
    assign commit_rd    = cmt_bus.rd;
    assign commit_value = cmt_bus.value;

endmodule

/* testbench/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reset is held low through the first two rising edges
    initial begin
        rst = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
    end

endmodule

/* testbench/ooo_core_tb.sv */
`timescale 1ns/1ps

module ooo_core_tb;

    localparam int REC_WORDS   = 9;
    localparam int MAX_INSTR   = 28;
    localparam int BURST_LEN   = 10;
    localparam int IDLE_CHECKS = 10;
    localparam int DRAIN_TAIL  = 5;

    logic              clk;
    logic              rst;
    logic              issue_valid;
    ooo_pkg::op_t      issue_op;
    ooo_pkg::reg_idx_t issue_rd;
    ooo_pkg::reg_idx_t issue_rs1;
    ooo_pkg::reg_idx_t issue_rs2;
    ooo_pkg::data_t    issue_imm;
    logic              credit;
    logic              commit_valid;
    ooo_pkg::reg_idx_t commit_rd;
    ooo_pkg::data_t    commit_value;
    logic              commit_branch;
    logic              commit_taken;

    logic [31:0] vectors [0:255];
    int          num_instr;
    int          cycle_count = 0;
    int          cycle_limit = 1000;

    clock_gen clocks (
        .clk,
        .rst
    );

    ooo_core uut (
        .clk, .rst, .issue_valid, .issue_op, .issue_rd, .issue_rs1, .issue_rs2, .issue_imm,
        .credit, .commit_valid, .commit_rd, .commit_value, .commit_branch, .commit_taken
    );

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_reg_idx(input string name, input ooo_pkg::reg_idx_t expected,
                                 input ooo_pkg::reg_idx_t actual);
        if (actual !== expected)
            fail_run($sformatf("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual));
    endtask

    task automatic check_data(input string name, input ooo_pkg::data_t expected,
                              input ooo_pkg::data_t actual);
        if (actual !== expected)
            fail_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, expected, actual));
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            fail_run($sformatf("CHECK FAILED %s: expected %b, actual %b", name, expected, actual));
    endtask

    // Record layout: op rd rs1 rs2 imm, then expected rd value branch taken
    task automatic drive_issue(input int idx);
        int base;
        base = 1 + REC_WORDS * idx;
        issue_valid <= 1'b1;
        issue_op    <= vectors[base][3:0];
        issue_rd    <= vectors[base + 1][4:0];
        issue_rs1   <= vectors[base + 2][4:0];
        issue_rs2   <= vectors[base + 3][4:0];
        issue_imm   <= vectors[base + 4];
    endtask

    task automatic check_commit(input int idx);
        int base;
        base = 1 + REC_WORDS * idx;
        check_reg_idx($sformatf("commit %0d rd", idx), vectors[base + 5][4:0], commit_rd);
        check_data($sformatf("commit %0d value", idx), vectors[base + 6], commit_value);
        check_flag($sformatf("commit %0d branch", idx), vectors[base + 7][0], commit_branch);
        check_flag($sformatf("commit %0d taken", idx), vectors[base + 8][0], commit_taken);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit)
            fail_run($sformatf("Timeout after %0d cycles, commits still missing", cycle_count));
    end

    initial begin
        int          issued;
        int          committed;
        int          credits;
        int          min_credits;
        int          pulses;
        logic [31:0] rnd;

        issue_valid = 1'b0;
        issue_op    = '0;
        issue_rd    = '0;
        issue_rs1   = '0;
        issue_rs2   = '0;
        issue_imm   = '0;
        issued      = 0;
        committed   = 0;
        credits     = ooo_pkg::ROB_DEPTH;
        min_credits = ooo_pkg::ROB_DEPTH;
        pulses      = 0;
        rnd         = 32'hbd9f_d47a;

        $readmemh("testbench/ooo_core_vectors.txt", vectors);
        if ($isunknown(vectors[0]) || vectors[0] == 0 || vectors[0] > MAX_INSTR)
            fail_run("Vector file is missing or holds a bad instruction count");
        num_instr   = vectors[0];
        cycle_limit = 20 * num_instr + 50;

        while (!rst)
            @(posedge clk);

        // Nothing may come out of an idle core
        repeat (IDLE_CHECKS) begin
            @(posedge clk);
            check_flag("idle commit_valid", 1'b0, commit_valid);
            check_flag("idle credit", 1'b0, credit);
        end

        // The first instructions go back to back so the ROB fills up
        while (committed < num_instr) begin
            @(posedge clk);
            if (credit) begin
                credits++;
                pulses++;
            end
            if (commit_valid) begin
                check_commit(committed);
                committed++;
            end
            rnd = next_random(rnd);
            if (issued < num_instr && credits > 0 &&
                (issued < BURST_LEN || rnd[31:30] != 2'b00)) begin
                drive_issue(issued);
                issued++;
                credits--;
                if (credits < min_credits)
                    min_credits = credits;
            end else begin
                issue_valid <= 1'b0;
            end
        end

        repeat (DRAIN_TAIL) begin
            @(posedge clk);
            if (credit) begin
                credits++;
                pulses++;
            end
            check_flag("drain commit_valid", 1'b0, commit_valid);
        end

        if (credits == ooo_pkg::ROB_DEPTH && pulses == num_instr && issued == num_instr &&
            min_credits == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            fail_run($sformatf("Credit accounting wrong: %0d held, %0d pulses, %0d issued, %0d %s",
                               credits, pulses, issued, min_credits, "lowest count"));
        end
    end

endmodule

/* testbench/ooo_core_vectors.txt */
// First word is the instruction count in hex. Each line after it is one instruction:
// op rd rs1 rs2 imm, then its expected commit: rd value branch taken
15
6 01 00 00 00000005  01 00000005 0 0
0 02 01 01 00000000  02 0000000a 0 0
1 03 02 01 00000000  03 00000005 0 0
7 04 00 00 12345000  04 12345000 0 0
4 05 04 03 00000000  05 12345005 0 0
6 06 00 00 fffffffd  06 fffffffd 0 0
5 07 06 01 00000000  07 00000001 0 0
2 08 05 06 00000000  08 12345005 0 0
3 00 02 03 00000000  00 0000000f 0 0
0 09 00 07 00000000  09 00000001 0 0
8 00 01 03 00000000  00 00000000 1 1
9 00 01 03 00000000  00 00000000 1 0
8 00 02 00 00000000  00 00000000 1 0
9 00 06 00 00000000  00 00000000 1 1
5 0a 01 06 00000000  0a 00000000 0 0
1 0b 00 01 00000000  0b fffffffb 0 0
6 01 01 00 00000100  01 00000105 0 0
0 0c 01 0b 00000000  0c 00000100 0 0
4 0d 0c 04 00000000  0d 12345100 0 0
7 00 00 00 abcde000  00 abcde000 0 0
3 0e 00 0d 00000000  0e 12345100 0 0

/* ooo_core.f */
verilog/ooo_pkg.sv
verilog/issue_if.sv
verilog/result_ifs.sv
verilog/rename_table.sv
verilog/reorder_buffer.sv
verilog/reservation_station.sv
verilog/execute_unit.sv
verilog/ooo_core.sv
testbench/clock_gen.sv
testbench/ooo_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module ooo_core_tb -f ooo_core.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/Vooo_core_tb 2>&1)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -q "^RESULT: PASS$"; then
    exit 0
fi

echo "Pass line not found in simulation output"
exit 1
